// ==== rtl/calc_pkg.sv ====
package calc_pkg;

  localparam int DWORD_WIDTH    = 64;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int PC_WIDTH       = 32;

  // Major opcodes of the kept integer operations
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef struct packed {
    logic [6:0]                funct7;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [6:0]                opcode;
  } rtype_s;

  typedef struct packed {
    logic [11:0]               imm12;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [6:0]                opcode;
  } itype_s;

  // Same instruction word, seen through either format
  typedef union packed {
    rtype_s rtype;
    itype_s itype;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_XOR,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic                      pipe_int_v;
    logic                      pipe_mul_v;
    logic                      irf_w_v;
    logic                      use_imm;
    alu_op_e                   alu_op;
    logic [DWORD_WIDTH-1:0]    imm;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
  } decode_s;

  typedef struct packed {
    logic [PC_WIDTH-1:0]    pc;
    instr_u                 instr;
    logic [DWORD_WIDTH-1:0] rs1;
    logic [DWORD_WIDTH-1:0] rs2;
  } dispatch_pkt_s;

  // Operands as they leave the reservation register
  typedef struct packed {
    decode_s                decode;
    logic [DWORD_WIDTH-1:0] rs1;
    logic [DWORD_WIDTH-1:0] rs2;
  } issue_s;

  typedef struct packed {
    logic                      v;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DWORD_WIDTH-1:0]    data;
  } fwd_s;

  typedef struct packed {
    logic                      v;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DWORD_WIDTH-1:0]    rd_data;
  } wb_pkt_s;

endpackage

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  calc_pkg::instr_u  instr_i,
  output calc_pkg::decode_s decode_o
);

  localparam logic [2:0] funct3_add_lp = 3'b000;
  localparam logic [2:0] funct3_sll_lp = 3'b001;
  localparam logic [2:0] funct3_xor_lp = 3'b100;
  localparam logic [2:0] funct3_or_lp  = 3'b110;
  localparam logic [2:0] funct3_and_lp = 3'b111;

  localparam logic [6:0] funct7_base_lp = 7'b0000000;
  localparam logic [6:0] funct7_sub_lp  = 7'b0100000;

  always_comb
  begin
    decode_o         = '0;
    decode_o.alu_op  = calc_pkg::ALU_ADD;
    decode_o.rd_addr = instr_i.rtype.rd_addr;
    // imm12 only matters for OP_IMM, the ALU ignores it otherwise
    decode_o.imm     = {{(calc_pkg::DWORD_WIDTH-12){instr_i.itype.imm12[11]}},
                        instr_i.itype.imm12};

    case (instr_i.rtype.opcode)
      calc_pkg::OPCODE_OP:
      begin
        if (instr_i.rtype.funct7 == calc_pkg::FUNCT7_MULDIV)
          decode_o.pipe_mul_v = (instr_i.rtype.funct3 == funct3_add_lp);
        else if (instr_i.rtype.funct7 == funct7_sub_lp)
        begin
          decode_o.pipe_int_v = (instr_i.rtype.funct3 == funct3_add_lp);
          decode_o.alu_op     = calc_pkg::ALU_SUB;
        end
        else if (instr_i.rtype.funct7 == funct7_base_lp)
        begin
          decode_o.pipe_int_v = 1'b1;
          case (instr_i.rtype.funct3)
            funct3_add_lp: decode_o.alu_op = calc_pkg::ALU_ADD;
            funct3_sll_lp: decode_o.alu_op = calc_pkg::ALU_SLL;
            funct3_xor_lp: decode_o.alu_op = calc_pkg::ALU_XOR;
            funct3_or_lp:  decode_o.alu_op = calc_pkg::ALU_OR;
            funct3_and_lp: decode_o.alu_op = calc_pkg::ALU_AND;
            default:       decode_o.pipe_int_v = 1'b0;
          endcase
        end
      end
      calc_pkg::OPCODE_OP_IMM:
      begin
        decode_o.use_imm    = 1'b1;
        decode_o.pipe_int_v = 1'b1;
        case (instr_i.itype.funct3)
          funct3_add_lp: decode_o.alu_op = calc_pkg::ALU_ADD;
          funct3_xor_lp: decode_o.alu_op = calc_pkg::ALU_XOR;
          funct3_or_lp:  decode_o.alu_op = calc_pkg::ALU_OR;
          funct3_and_lp: decode_o.alu_op = calc_pkg::ALU_AND;
          default:       decode_o.pipe_int_v = 1'b0;
        endcase
      end
      default:
      begin
        decode_o.pipe_int_v = 1'b0;
      end
    endcase

    // Writes to x0 turn into a nop
    if (instr_i.rtype.rd_addr == '0)
    begin
      decode_o.pipe_int_v = 1'b0;
      decode_o.pipe_mul_v = 1'b0;
    end
    decode_o.irf_w_v = decode_o.pipe_int_v | decode_o.pipe_mul_v;
  end

endmodule

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass #(
  parameter int fwd_els_p = 4
) (
  input  calc_pkg::instr_u                      instr_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0]      rs1_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0]      rs2_i,
  input  calc_pkg::fwd_s [fwd_els_p-1:0]        fwd_i,
  output logic [calc_pkg::DWORD_WIDTH-1:0]      bypass_rs1_o,
  output logic [calc_pkg::DWORD_WIDTH-1:0]      bypass_rs2_o
);

  // Walk from the oldest tap to the youngest so that the youngest match wins
  function automatic logic [calc_pkg::DWORD_WIDTH-1:0] pick_operand(
    input logic [calc_pkg::REG_ADDR_WIDTH-1:0] addr,
    input logic [calc_pkg::DWORD_WIDTH-1:0]    arch_val,
    input calc_pkg::fwd_s [fwd_els_p-1:0]      fwd
  );
    logic [calc_pkg::DWORD_WIDTH-1:0] val;

    val = arch_val;
    for (int i = fwd_els_p - 1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr))
        val = fwd[i].data;
    end
    // x0 is hardwired, whatever the packet carries
    if (addr == '0)
      val = '0;
    return val;
  endfunction

  // rs1 sits at the same bits in both formats, rs2 is only meaningful for R-type
  always_comb
  begin
    bypass_rs1_o = pick_operand(instr_i.rtype.rs1_addr, rs1_i, fwd_i);
    bypass_rs2_o = pick_operand(instr_i.rtype.rs2_addr, rs2_i, fwd_i);
  end

endmodule

// ==== rtl/pipe_int.sv ====
`timescale 1ns/1ps

module pipe_int (
  input  calc_pkg::issue_s                 issue_i,
  output logic [calc_pkg::DWORD_WIDTH-1:0] data_o
);

  logic [calc_pkg::DWORD_WIDTH-1:0] src_a;
  logic [calc_pkg::DWORD_WIDTH-1:0] src_b;

  assign src_a = issue_i.rs1;
  assign src_b = issue_i.decode.use_imm ? issue_i.decode.imm : issue_i.rs2;

  always_comb
  begin
    case (issue_i.decode.alu_op)
      calc_pkg::ALU_ADD: data_o = src_a + src_b;
      calc_pkg::ALU_SUB: data_o = src_a - src_b;
      // RV64 shift amount is six bits
      calc_pkg::ALU_SLL: data_o = src_a << src_b[5:0];
      calc_pkg::ALU_XOR: data_o = src_a ^ src_b;
      calc_pkg::ALU_OR:  data_o = src_a | src_b;
      calc_pkg::ALU_AND: data_o = src_a & src_b;
      default:           data_o = '0;
    endcase
  end

endmodule

// ==== rtl/pipe_mul.sv ====
`timescale 1ns/1ps

module pipe_mul (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  calc_pkg::issue_s                 issue_i,
  output logic [calc_pkg::DWORD_WIDTH-1:0] data_o
);

  logic [calc_pkg::DWORD_WIDTH-1:0] product;
  logic [calc_pkg::DWORD_WIDTH-1:0] product_r;

  // Low half only, so a 64 bit result context is enough
  assign product = issue_i.rs1 * issue_i.rs2;

  // Loads only on a multiply, so a back to back pair each gets its own edge
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      product_r <= '0;
    end
    else if (issue_i.decode.pipe_mul_v)
    begin
      product_r <= product;
    end
  end

  assign data_o = product_r;

endmodule

// ==== rtl/completion_pipe.sv ====
`timescale 1ns/1ps

module completion_pipe #(
  parameter int fwd_els_p = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             dispatch_v_i,
  input  calc_pkg::dispatch_pkt_s          dispatch_pkt_i,
  input  calc_pkg::decode_s                decode_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0] rs1_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0] rs2_i,
  input  logic                             flush_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0] int_data_i,
  input  logic [calc_pkg::DWORD_WIDTH-1:0] mul_data_i,
  output calc_pkg::issue_s                 issue_o,
  output calc_pkg::fwd_s [fwd_els_p-1:0]   fwd_o,
  output calc_pkg::wb_pkt_s                wb_pkt_o
);

  localparam int tap_els_lp = 4;

  calc_pkg::issue_s                issue_n;
  calc_pkg::issue_s                issue_r;
  calc_pkg::fwd_s [tap_els_lp-1:0] taps;

  // Stage 1 is the reservation register
  logic [3:1]                                    poison_r;
  logic [3:1]                                    poison_n;
  logic [3:1][calc_pkg::PC_WIDTH-1:0]            pc_r;
  logic [3:2]                                    w_r;
  logic [3:2][calc_pkg::REG_ADDR_WIDTH-1:0]      rd_r;
  logic [3:2][calc_pkg::DWORD_WIDTH-1:0]         data_r;
  logic [4:2][calc_pkg::DWORD_WIDTH-1:0]         data_n;
  logic                                          st2_mul_r;

  logic                                          wb_v_r;
  logic [calc_pkg::PC_WIDTH-1:0]                 wb_pc_r;
  logic [calc_pkg::REG_ADDR_WIDTH-1:0]           wb_rd_r;
  logic [calc_pkg::DWORD_WIDTH-1:0]              wb_data_r;

  // Only a real dispatch may start a pipe or claim a write
  always_comb
  begin
    issue_n                   = '0;
    issue_n.decode            = decode_i;
    issue_n.decode.pipe_int_v = decode_i.pipe_int_v & dispatch_v_i;
    issue_n.decode.pipe_mul_v = decode_i.pipe_mul_v & dispatch_v_i;
    issue_n.decode.irf_w_v    = decode_i.irf_w_v & dispatch_v_i;
    issue_n.rs1               = rs1_i;
    issue_n.rs2               = rs2_i;
  end

  // Flush reaches the three youngest stages but not the writeback register
  assign poison_n[1] = flush_i;
  assign poison_n[2] = poison_r[1] | flush_i;
  assign poison_n[3] = poison_r[2] | flush_i;

  // Integer result lands in stage 2 and multiply result in stage 3
  assign data_n[2] = issue_r.decode.pipe_int_v ? int_data_i : '0;
  assign data_n[3] = st2_mul_r ? mul_data_i : data_r[2];
  assign data_n[4] = data_r[3];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      issue_r   <= '0;
      poison_r  <= '0;
      w_r       <= '0;
      st2_mul_r <= 1'b0;
      wb_v_r    <= 1'b0;
    end
    else
    begin
      issue_r   <= issue_n;
      poison_r  <= poison_n;
      w_r[2]    <= issue_r.decode.irf_w_v;
      w_r[3]    <= w_r[2];
      st2_mul_r <= issue_r.decode.pipe_mul_v;
      wb_v_r    <= w_r[3] & ~poison_r[3];
    end
  end

  always_ff @(posedge clk_i)
  begin
    pc_r[1]   <= dispatch_pkt_i.pc;
    pc_r[2]   <= pc_r[1];
    pc_r[3]   <= pc_r[2];
    rd_r[2]   <= issue_r.decode.rd_addr;
    rd_r[3]   <= rd_r[2];
    data_r[2] <= data_n[2];
    data_r[3] <= data_n[3];
    wb_pc_r   <= pc_r[3];
    wb_rd_r   <= rd_r[3];
    wb_data_r <= data_n[4];
  end

  assign issue_o = issue_r;

  // Taps run youngest first and each carries the value its stage will hold next
  assign taps[0] = '{v: issue_r.decode.irf_w_v & ~poison_n[2],
                     rd_addr: issue_r.decode.rd_addr, data: data_n[2]};
  assign taps[1] = '{v: w_r[2] & ~poison_n[3], rd_addr: rd_r[2], data: data_n[3]};
  assign taps[2] = '{v: w_r[3] & ~poison_r[3], rd_addr: rd_r[3], data: data_n[4]};
  assign taps[3] = '{v: wb_v_r, rd_addr: wb_rd_r, data: wb_data_r};

  for (genvar i = 0; i < fwd_els_p; i++)
  begin : g_fwd
    if (i < tap_els_lp)
    begin : g_tap
      assign fwd_o[i] = taps[i];
    end
    else
    begin : g_pad
      assign fwd_o[i] = '0;
    end
  end

  assign wb_pkt_o = '{v: wb_v_r, pc: wb_pc_r, rd_addr: wb_rd_r, rd_data: wb_data_r};

  // Dispatcher must hold off a reader of a multiply for one cycle
  a_mul_hazard: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dispatch_v_i && (decode_i.pipe_int_v || decode_i.pipe_mul_v)
     && issue_r.decode.pipe_mul_v && !poison_n[2])
    |-> (dispatch_pkt_i.instr.rtype.rs1_addr != issue_r.decode.rd_addr)
        && (decode_i.use_imm
            || (dispatch_pkt_i.instr.rtype.rs2_addr != issue_r.decode.rd_addr)));

  // Flush kills the dispatches at its own edge and the two before it
  a_flush_kills: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> ##2 !wb_pkt_o.v ##1 !wb_pkt_o.v ##1 !wb_pkt_o.v);

endmodule

// ==== rtl/calc_top.sv ====
`timescale 1ns/1ps

module calc_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    dispatch_v_i,
  input  calc_pkg::dispatch_pkt_s dispatch_pkt_i,
  input  logic                    flush_i,
  output calc_pkg::wb_pkt_s       wb_pkt_o
);

  // Enough taps to cover everything between dispatch and writeback
  localparam int fwd_els_lp = 4;

  calc_pkg::decode_s                decode;
  calc_pkg::issue_s                 issue;
  calc_pkg::fwd_s [fwd_els_lp-1:0]  fwd;

  logic [calc_pkg::DWORD_WIDTH-1:0] bypass_rs1;
  logic [calc_pkg::DWORD_WIDTH-1:0] bypass_rs2;
  logic [calc_pkg::DWORD_WIDTH-1:0] int_data;
  logic [calc_pkg::DWORD_WIDTH-1:0] mul_data;

  instr_decoder u_decoder (
    .instr_i  (dispatch_pkt_i.instr),
    .decode_o (decode)
  );

  operand_bypass #(
    .fwd_els_p (fwd_els_lp)
  ) u_bypass (
    .instr_i      (dispatch_pkt_i.instr),
    .rs1_i        (dispatch_pkt_i.rs1),
    .rs2_i        (dispatch_pkt_i.rs2),
    .fwd_i        (fwd),
    .bypass_rs1_o (bypass_rs1),
    .bypass_rs2_o (bypass_rs2)
  );

  completion_pipe #(
    .fwd_els_p (fwd_els_lp)
  ) u_completion (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_v_i   (dispatch_v_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .decode_i       (decode),
    .rs1_i          (bypass_rs1),
    .rs2_i          (bypass_rs2),
    .flush_i        (flush_i),
    .int_data_i     (int_data),
    .mul_data_i     (mul_data),
    .issue_o        (issue),
    .fwd_o          (fwd),
    .wb_pkt_o       (wb_pkt_o)
  );

  // One cycle integer pipe
  pipe_int u_pipe_int (
    .issue_i (issue),
    .data_o  (int_data)
  );

  // Two cycle multiply pipe
  pipe_mul u_pipe_mul (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .issue_i (issue),
    .data_o  (mul_data)
  );

endmodule

// ==== test/calc_tb.sv ====
`timescale 1ns/1ps

module calc_tb;

  typedef struct {
    int unsigned due;
    logic        writes;
    logic        killed;
    logic [4:0]  rd;
    logic [63:0] data;
    logic [31:0] pc;
  } exp_entry_t;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    dispatch_v_i;
  calc_pkg::dispatch_pkt_s dispatch_pkt_i;
  logic                    flush_i;
  calc_pkg::wb_pkt_s       wb_pkt_o;

  logic [63:0]  arch_rf [32];
  exp_entry_t   exp_q [$];
  int unsigned  cyc;
  logic [31:0]  pc_cnt;
  logic         last_mul_v;
  logic [4:0]   last_mul_rd;

  calc_top UUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_v_i   (dispatch_v_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .flush_i        (flush_i),
    .wb_pkt_o       (wb_pkt_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Expected result from the ISA rules, bit 64 says whether rd is written
  function automatic logic [64:0] ref_exec(logic [31:0] w, logic [63:0] a, logic [63:0] b);
    logic [63:0] imm;
    logic [63:0] r;
    logic        ok;

    imm = {{52{w[31]}}, w[31:20]};
    ok  = 1'b1;
    r   = '0;
    if (w[6:0] == 7'h33 && w[31:25] == 7'h01 && w[14:12] == 3'd0)
      r = a * b;
    else if (w[6:0] == 7'h33 && w[31:25] == 7'h20 && w[14:12] == 3'd0)
      r = a - b;
    else if (w[6:0] == 7'h33 && w[31:25] == 7'h00)
    begin
      case (w[14:12])
        3'd0:    r = a + b;
        3'd1:    r = a << b[5:0];
        3'd4:    r = a ^ b;
        3'd6:    r = a | b;
        3'd7:    r = a & b;
        default: ok = 1'b0;
      endcase
    end
    else if (w[6:0] == 7'h13)
    begin
      case (w[14:12])
        3'd0:    r = a + imm;
        3'd4:    r = a ^ imm;
        3'd6:    r = a | imm;
        3'd7:    r = a & imm;
        default: ok = 1'b0;
      endcase
    end
    else
      ok = 1'b0;
    if (w[11:7] == 5'd0)
      ok = 1'b0;
    return {ok, r};
  endfunction

  // Golden register value in program order, killed entries skipped
  function automatic logic [63:0] model_read(logic [4:0] r);
    if (r == 5'd0)
      return '0;
    for (int i = exp_q.size() - 1; i >= 0; i--)
    begin
      if (exp_q[i].writes && !exp_q[i].killed && exp_q[i].rd == r)
        return exp_q[i].data;
    end
    return arch_rf[r];
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  // Random op on a small register window, never reading the previous cycle's MUL target
  function automatic logic [31:0] random_instr();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    logic [31:0] w;

    rd  = 5'($urandom_range(0, 7));
    imm = 12'($urandom);
    do rs1 = 5'($urandom_range(0, 7)); while (last_mul_v && rs1 == last_mul_rd);
    do rs2 = 5'($urandom_range(0, 7)); while (last_mul_v && rs2 == last_mul_rd);
    case ($urandom_range(0, 11))
      0:       w = enc_r(7'h00, rs2, rs1, 3'd0, rd);
      1:       w = enc_r(7'h20, rs2, rs1, 3'd0, rd);
      2:       w = enc_r(7'h00, rs2, rs1, 3'd1, rd);
      3:       w = enc_r(7'h00, rs2, rs1, 3'd4, rd);
      4:       w = enc_r(7'h00, rs2, rs1, 3'd6, rd);
      5:       w = enc_r(7'h00, rs2, rs1, 3'd7, rd);
      6:       w = enc_i(imm, rs1, 3'd0, rd);
      7:       w = enc_i(imm, rs1, 3'd4, rd);
      8:       w = enc_i(imm, rs1, 3'd6, rd);
      9:       w = enc_i(imm, rs1, 3'd7, rd);
      10:      w = enc_r(7'h01, rs2, rs1, 3'd0, rd);
      // Unknown: a load, a DIV and an SLLI
      default: w = ($urandom_range(0, 2) == 0) ? {imm, rs1, 3'd3, rd, 7'h03}
                 : ($urandom_range(0, 1) == 0) ? enc_r(7'h01, rs2, rs1, 3'd4, rd)
                 : enc_i(imm, rs1, 3'd1, rd);
    endcase
    return w;
  endfunction

  // One clock of stimulus; the dispatch lands at edge cyc + 1
  task automatic next_cycle(input logic v, input logic [31:0] w, input logic fl);
    calc_pkg::dispatch_pkt_s pkt;
    exp_entry_t              e;
    logic [64:0]             res;

    @(posedge clk_i);
    cyc++;
    pkt.pc    = pc_cnt;
    pkt.instr = w;
    pkt.rs1   = (w[19:15] == 5'd0) ? {$urandom, $urandom} : arch_rf[w[19:15]];
    pkt.rs2   = (w[24:20] == 5'd0) ? {$urandom, $urandom} : arch_rf[w[24:20]];
    if (v)
    begin
      res      = ref_exec(w, model_read(w[19:15]), model_read(w[24:20]));
      e.due    = cyc + 4;
      e.writes = res[64];
      e.killed = 1'b0;
      e.rd     = w[11:7];
      e.data   = res[63:0];
      e.pc     = pc_cnt;
      exp_q.push_back(e);
      pc_cnt   = pc_cnt + 32'd4;
    end
    // Kill dispatches from this edge and the two before it
    if (fl)
    begin
      foreach (exp_q[i])
      begin
        if (exp_q[i].due >= cyc + 2)
          exp_q[i].killed = 1'b1;
      end
    end
    last_mul_v  = v && (w[6:0] == 7'h33) && (w[31:25] == 7'h01) && (w[14:12] == 3'd0)
                  && (w[11:7] != 5'd0);
    last_mul_rd = w[11:7];
    dispatch_v_i   <= v;
    dispatch_pkt_i <= pkt;
    flush_i        <= fl;
  endtask

  // Writeback compare, half a cycle after the edge
  always @(negedge clk_i)
  begin
    exp_entry_t e;
    logic       exp_v;

    exp_v = 1'b0;
    if (rst_n_i)
    begin
      if (exp_q.size() > 0 && exp_q[0].due == cyc)
      begin
        e     = exp_q.pop_front();
        exp_v = e.writes && !e.killed;
      end
      if (exp_v)
      begin
        assert (wb_pkt_o.v)
        else begin
          $display("Missing writeback for pc %h at edge %0d", e.pc, cyc);
          $display("TEST FAIL");
          $fatal(1);
        end
        assert (wb_pkt_o.rd_addr == e.rd)
        else begin
          $display("CHECK FAILED wb_pkt_o.rd_addr expected %h got %h", e.rd, wb_pkt_o.rd_addr);
          $display("TEST FAIL");
          $fatal(1);
        end
        assert (wb_pkt_o.rd_data == e.data)
        else begin
          $display("CHECK FAILED wb_pkt_o.rd_data expected %h got %h", e.data,
                   wb_pkt_o.rd_data);
          $display("TEST FAIL");
          $fatal(1);
        end
        assert (wb_pkt_o.pc == e.pc)
        else begin
          $display("CHECK FAILED wb_pkt_o.pc expected %h got %h", e.pc, wb_pkt_o.pc);
          $display("TEST FAIL");
          $fatal(1);
        end
        arch_rf[e.rd] = e.data;
      end
      else
      begin
        assert (!wb_pkt_o.v)
        else begin
          $display("Unexpected writeback to x%0d at edge %0d", wb_pkt_o.rd_addr, cyc);
          $display("TEST FAIL");
          $fatal(1);
        end
      end
    end
  end

  initial
  begin
    int unsigned seed_r;
    int          waited;

    seed_r         = $urandom(32'h49ea15ae);
    rst_n_i        = 1'b0;
    dispatch_v_i   = 1'b0;
    dispatch_pkt_i = '0;
    flush_i        = 1'b0;
    cyc            = 0;
    pc_cnt         = 32'h1000;
    last_mul_v     = 1'b0;
    last_mul_rd    = '0;
    foreach (arch_rf[i])
      arch_rf[i] = '0;

    repeat (8) next_cycle(1'b0, '0, 1'b0);
    rst_n_i <= 1'b1;
    // Quiet after reset
    repeat (5) next_cycle(1'b0, $urandom, 1'b0);

    // Producers read back at distances one to four
    next_cycle(1'b1, enc_i(12'h123, 5'd0, 3'd0, 5'd1), 1'b0);
    next_cycle(1'b1, enc_i(12'hffb, 5'd1, 3'd0, 5'd2), 1'b0);
    next_cycle(1'b1, enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b0);
    next_cycle(1'b0, $urandom, 1'b0);
    next_cycle(1'b1, enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4), 1'b0);
    repeat (2) next_cycle(1'b0, $urandom, 1'b0);
    next_cycle(1'b1, enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5), 1'b0);

    // Two multiplies in a row, then a reader two cycles on
    next_cycle(1'b1, enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd6), 1'b0);
    next_cycle(1'b1, enc_r(7'h01, 5'd4, 5'd3, 3'd0, 5'd7), 1'b0);
    next_cycle(1'b0, $urandom, 1'b0);
    next_cycle(1'b1, enc_r(7'h01, 5'd7, 5'd6, 3'd0, 5'd8), 1'b0);

    // x0 writes and reads
    next_cycle(1'b1, enc_i(12'h005, 5'd1, 3'd0, 5'd0), 1'b0);
    next_cycle(1'b1, enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd9), 1'b0);

    // Flush on the third dispatch kills all three
    next_cycle(1'b1, enc_i(12'h007, 5'd0, 3'd0, 5'd10), 1'b0);
    next_cycle(1'b1, enc_i(12'h001, 5'd0, 3'd0, 5'd11), 1'b0);
    next_cycle(1'b1, enc_i(12'h001, 5'd10, 3'd0, 5'd10), 1'b1);
    next_cycle(1'b1, enc_r(7'h00, 5'd11, 5'd10, 3'd0, 5'd12), 1'b0);

    for (int n = 0; n < 600; n++)
    begin
      if ($urandom_range(0, 3) == 0)
        next_cycle(1'b0, $urandom, ($urandom_range(0, 15) == 0));
      else
        next_cycle(1'b1, random_instr(), ($urandom_range(0, 15) == 0));
    end

    waited = 0;
    while (exp_q.size() != 0)
    begin
      if (waited > 20)
      begin
        $display("Timed out waiting for outstanding writebacks");
        $display("TEST FAIL");
        $fatal(1);
      end
      next_cycle(1'b0, $urandom, 1'b0);
      waited++;
    end
    repeat (3) next_cycle(1'b0, $urandom, 1'b0);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/calc_pkg.sv
rtl/instr_decoder.sv
rtl/operand_bypass.sv
rtl/pipe_int.sv
rtl/pipe_mul.sv
rtl/completion_pipe.sv
rtl/calc_top.sv
test/calc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the calc_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module calc_tb -f filelist.f -o calc_sim \
  && ./obj_dir/calc_sim \
  || exit 1
